// File: alu_top.f
+incdir+include
hw/alu_op_pkg.sv
hw/alu_result_pkg.sv
hw/alu_operand_stage.sv
hw/alu_bit_slice.sv
hw/alu_result_stage.sv
hw/alu_top.sv
tb/alu_top_assertions.sv
tb/alu_top_tb.sv

// File: hw/alu_bit_slice.sv
`timescale 1ns/1ps

module alu_bit_slice (
  input  logic i_a,
  input  logic i_b,
  input  logic i_carry,
  output logic o_sum,
  output logic o_carry,
  output logic o_eq
);

  // propagate and generate terms of the full adder
  logic prop;
  logic gen;

  // b here is already inverted for sub and compare
  assign prop = i_a ^ i_b;
  assign gen  = i_a & i_b;

  // sum bit
  assign o_sum = prop ^ i_carry;

  // ripple carry to the next bit
  // carry out when both set, or one set with a carry in
  assign o_carry = gen | (prop & i_carry);

  // with b inverted, prop high means the original bits matched
  // only meaningful for a compare
  // the result stage ands these across the word
  assign o_eq = prop;

  // every bit of the word uses this same slice
  // bit 0 gets its carry in from the operand stage
  // so there is no separate half adder cell
  // the top bit's carry out is the word carry
  // for a sub it is the inverse of the borrow
  // for a compare it is high when a >= b
  // timing is purely combinational
  // the chain sits between two register stages

endmodule

// File: hw/alu_op_pkg.sv
`include "alu_macros.svh"

package alu_op_pkg;

  // operation codes accepted on i_op
  // sub and compare share the inverted operand path
  // reserved code runs through the add path
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_CMP  = 2'd2,
    OP_RSVD = 2'd3
  } alu_op_e;

  // sub and compare both compute a + ~b + 1
  // op decode lives in the operand stage
  // the result stage decodes op again to pick the output view
  // op 3 is never flagged as an error

endpackage

// File: hw/alu_operand_stage.sv
`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_operand_stage (
  input  logic                      RESET,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  alu_op_pkg::alu_op_e       i_op,
  input  logic [`ALU_WIDTH-1:0]     i_a,
  input  logic [`ALU_WIDTH-1:0]     i_b,
  output logic                      o_valid,
  output alu_op_pkg::alu_op_e       o_op,
  output logic [`ALU_WIDTH-1:0]     o_a,
  output logic [`ALU_WIDTH-1:0]     o_b_prep,
  output logic                      o_carry_in
);

  // high for ops that take a + ~b + 1
  logic                  sub_path;
  // b as the slices should see it
  logic [`ALU_WIDTH-1:0] b_prep_d;
  // carry into bit 0
  logic                  carry_in_d;

  // one decode for the whole word
  always_comb begin
    case (i_op)
      alu_op_pkg::OP_SUB: begin
        sub_path = 1'b1;
      end
      alu_op_pkg::OP_CMP: begin
        sub_path = 1'b1;
      end
      default: begin
        // add and reserved
        sub_path = 1'b0;
      end
    endcase
  end

  // two's complement negation with the +1 entering as carry in
  assign b_prep_d   = sub_path ? ~i_b : i_b;
  assign carry_in_d = sub_path;

  // strobe follows i_valid one cycle later
  always_ff @(posedge RESET) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // payload only loads with a valid operation
  // holds its last value on idle cycles
  always_ff @(posedge RESET) begin
    if (i_valid) begin
      o_op       <= i_op;
      o_a        <= i_a;
      o_b_prep   <= b_prep_d;
      o_carry_in <= carry_in_d;
    end
  end

  // o_op passes on so the result stage picks the view
  // the inverted b and carry in already encode sub vs add
  // compare and sub differ only in the output stage

endmodule

// File: hw/alu_result_pkg.sv
`include "alu_macros.svh"

package alu_result_pkg;

  // compare outcome packed into a result-sized word
  // exactly one of lt, eq, gt is set for a compare
  // gt sits in bit 0, eq in bit 1, lt in bit 2
  typedef struct packed {
    logic [`ALU_WIDTH-4:0] pad;
    logic                  lt;
    logic                  eq;
    logic                  gt;
  } cmp_flags_s;

  // one result word read two ways
  // word for add and sub, flags for a compare
  typedef union packed {
    logic [`ALU_WIDTH-1:0] word;
    cmp_flags_s            flags;
  } alu_result_u;

  // the padding bits of the flag view are always written as zero
  // a compare never drives the carry output
  // add and sub results wrap modulo 2^ALU_WIDTH
  // sub reports a borrow on the carry output

endpackage

// File: hw/alu_result_stage.sv
`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_result_stage (
  input  logic                        RESET,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  alu_op_pkg::alu_op_e         i_op,
  input  logic [`ALU_WIDTH-1:0]       i_sum,
  input  logic [`ALU_WIDTH-1:0]       i_eq,
  input  logic                        i_carry,
  output logic                        o_valid,
  output alu_result_pkg::alu_result_u o_result,
  output logic                        o_carry
);

  // all bit positions equal
  logic                        eq_all;
  // compare flags from the final carry
  logic                        cmp_lt;
  logic                        cmp_gt;
  // next result and carry
  alu_result_pkg::alu_result_u result_d;
  logic                        carry_d;

  // equality chain over the whole word
  assign eq_all = &i_eq;

  // final carry high means a >= b
  // so a carry without equality is strictly greater
  assign cmp_gt = i_carry & ~eq_all;
  assign cmp_lt = ~i_carry;

  // pick the result view for the op
  always_comb begin
    result_d = '0;
    carry_d  = 1'b0;
    case (i_op)
      alu_op_pkg::OP_SUB: begin
        result_d.word = i_sum;
        // borrow is the missing carry
        carry_d       = ~i_carry;
      end
      alu_op_pkg::OP_CMP: begin
        result_d.flags.pad = '0;
        result_d.flags.lt  = cmp_lt;
        result_d.flags.eq  = eq_all;
        result_d.flags.gt  = cmp_gt;
        // compare never reports a carry
        carry_d            = 1'b0;
      end
      default: begin
        // add and reserved
        result_d.word = i_sum;
        carry_d       = i_carry;
      end
    endcase
  end

  // result strobe
  always_ff @(posedge RESET) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // result word and carry
  // load only with a valid operation
  // outputs read zero until the first result
  always_ff @(posedge RESET) begin
    if (!i_rst_n) begin
      o_result <= '0;
      o_carry  <= 1'b0;
    end else if (i_valid) begin
      o_result <= result_d;
      o_carry  <= carry_d;
    end
  end

  // a result is valid for the single cycle o_valid is high
  // the word holds afterwards but carries no meaning
  // the next result may follow directly as there is no back-pressure

endmodule

// File: hw/alu_top.sv
`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_top (
  input  logic                  RESET,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  alu_op_pkg::alu_op_e   i_op,
  input  logic [`ALU_WIDTH-1:0] i_a,
  input  logic [`ALU_WIDTH-1:0] i_b,
  output logic                  o_valid,
  output logic [`ALU_WIDTH-1:0] o_result,
  output logic                  o_carry
);

  // operand stage outputs
  logic                  op_valid;
  alu_op_pkg::alu_op_e   op_code;
  logic [`ALU_WIDTH-1:0] op_a;
  logic [`ALU_WIDTH-1:0] op_b_prep;

  // carry chain with bit 0 from the operand stage
  // the top bit goes to the result stage
  logic [`ALU_WIDTH:0]   carry;
  // per-bit slice outputs
  logic [`ALU_WIDTH-1:0] sum;
  logic [`ALU_WIDTH-1:0] eq;

  // stage 1 registers the operands and prepares b
  alu_operand_stage u_operand_stage (
    .RESET      (RESET),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_a        (i_a),
    .i_b        (i_b),
    .o_valid    (op_valid),
    .o_op       (op_code),
    .o_a        (op_a),
    .o_b_prep   (op_b_prep),
    .o_carry_in (carry[0])
  );

  // ripple chain of identical slices
  genvar i;
  generate
    for (i = 0; i < `ALU_WIDTH; i = i + 1) begin : g_slice
      alu_bit_slice u_slice (
        .i_a     (op_a[i]),
        .i_b     (op_b_prep[i]),
        .i_carry (carry[i]),
        .o_sum   (sum[i]),
        .o_carry (carry[i+1]),
        .o_eq    (eq[i])
      );
    end
  endgenerate

  // stage 2 finishes the chains and registers the result
  // the union output lands on a plain word at the top
  alu_result_stage u_result_stage (
    .RESET    (RESET),
    .i_rst_n  (i_rst_n),
    .i_valid  (op_valid),
    .i_op     (op_code),
    .i_sum    (sum),
    .i_eq     (eq),
    .i_carry  (carry[`ALU_WIDTH]),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_carry  (o_carry)
  );

  // two register stages, so a result follows its input by two cycles
  // a new operation can enter every cycle

endmodule

// File: include/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath width shared by the operand stage, slices and result stage
// any width of 4 or more works
// the compare flag view needs at least one padding bit above lt, eq, gt
`define ALU_WIDTH 8

// operation code field
// four codes: add, sub, compare, reserved
`define ALU_OP_WIDTH 2

// result layout follows directly from ALU_WIDTH
// see alu_result_pkg for the word and flag views
// the slice chain always has one carry bit beyond the width

// operand and result words are unsigned throughout

`endif

// File: tb/alu_top_assertions.sv
`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_top_assertions (
  input logic                  RESET,
  input logic                  i_rst_n,
  input logic                  i_valid,
  input alu_op_pkg::alu_op_e   i_op,
  input logic                  o_valid,
  input logic [`ALU_WIDTH-1:0] o_result,
  input logic                  o_carry
);

  // flag view of the result word
  alu_result_pkg::alu_result_u result_view;

  assign result_view = o_result;

  // a reset cycle leaves no result strobe behind
  a_valid_low_in_reset: assert property (@(posedge RESET) !i_rst_n |=> !o_valid)
    else $error("o_valid high after a reset cycle");

  // fixed two-cycle pipeline
  a_valid_latency: assert property (@(posedge RESET) disable iff (!i_rst_n)
    o_valid == $past(i_valid, 2))
    else $error("o_valid does not follow i_valid by two cycles");

  a_cmp_no_carry: assert property (@(posedge RESET) disable iff (!i_rst_n)
    (o_valid && $past(i_op, 2) == alu_op_pkg::OP_CMP) |-> !o_carry)
    else $error("carry set on a compare result");

  // exactly one of lt, eq, gt
  a_cmp_one_flag: assert property (@(posedge RESET) disable iff (!i_rst_n)
    (o_valid && $past(i_op, 2) == alu_op_pkg::OP_CMP) |->
      (result_view.flags.pad == '0) &&
      $onehot({result_view.flags.lt, result_view.flags.eq, result_view.flags.gt}))
    else $error("compare result flags malformed");

endmodule

bind alu_top alu_top_assertions u_assertions (
  .RESET    (RESET),
  .i_rst_n  (i_rst_n),
  .i_valid  (i_valid),
  .i_op     (i_op),
  .o_valid  (o_valid),
  .o_result (o_result),
  .o_carry  (o_carry)
);

// File: tb/alu_top_tb.sv
`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_top_tb;

  localparam int W              = `ALU_WIDTH;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_RANDOM     = 300;

  logic                RESET;
  logic                i_rst_n;
  logic                i_valid;
  alu_op_pkg::alu_op_e i_op;
  logic [W-1:0]        i_a;
  logic [W-1:0]        i_b;
  logic                o_valid;
  logic [W-1:0]        o_result;
  logic                o_carry;

  // expected results in issue order
  logic [W-1:0] exp_word_q[$];
  logic         exp_carry_q[$];
  int           exp_cycle_q[$];

  int     cycle_cnt;
  int     issued;
  int     checked;
  integer seed;

  alu_top DUT (
    .RESET    (RESET),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_a      (i_a),
    .i_b      (i_b),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_carry  (o_carry)
  );

  always #20 RESET = ~RESET;

  // rising edges seen so far
  always @(posedge RESET) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // expected {carry, word}
  // a compare puts gt in bit 0, eq in bit 1, lt in bit 2
  function automatic logic [W:0] ref_alu(input alu_op_pkg::alu_op_e op,
                                         input logic [W-1:0] a, input logic [W-1:0] b);
    logic [W:0] res;
    res = '0;
    case (op)
      alu_op_pkg::OP_SUB: begin
        res[W-1:0] = a - b;
        res[W]     = (a < b);
      end
      alu_op_pkg::OP_CMP: begin
        if (a < b) res[2] = 1'b1;
        else if (a == b) res[1] = 1'b1;
        else res[0] = 1'b1;
      end
      default: begin
        res = {1'b0, a} + {1'b0, b};
      end
    endcase
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  task automatic drive_op(input alu_op_pkg::alu_op_e op, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    logic [W:0] expv;
    @(posedge RESET);
    #2;
    i_valid = 1'b1;
    i_op    = op;
    i_a     = a;
    i_b     = b;
    expv    = ref_alu(op, a, b);
    exp_word_q.push_back(expv[W-1:0]);
    exp_carry_q.push_back(expv[W]);
    // cycle in which the inputs are presented
    exp_cycle_q.push_back(cycle_cnt);
    issued++;
  endtask

  task automatic drive_idle();
    @(posedge RESET);
    #2;
    i_valid = 1'b0;
  endtask

  task automatic check_outputs_zero();
    check_value("o_valid", 0, o_valid);
    check_value("o_result", 0, o_result);
    check_value("o_carry", 0, o_carry);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_word_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge RESET);
      waited++;
    end
    if (exp_word_q.size() != 0) begin
      abort_run("timeout: issued operations never produced their results");
    end
  endtask

  always @(negedge RESET) begin : compare_results
    logic [W-1:0] exp_word;
    logic         exp_carry;
    int           issue_cycle;
    if (i_rst_n === 1'b1 && o_valid !== 1'b0) begin
      check_value("o_valid", 1, o_valid);
      if (exp_word_q.size() == 0) begin
        abort_run("a result strobe came with no operation outstanding");
      end else begin
        exp_word    = exp_word_q.pop_front();
        exp_carry   = exp_carry_q.pop_front();
        issue_cycle = exp_cycle_q.pop_front();
        check_value("o_result", exp_word, o_result);
        check_value("o_carry", exp_carry, o_carry);
        check_value("latency", 2, cycle_cnt - issue_cycle);
        checked++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rb;
    RESET     = 1'b0;
    i_rst_n   = 1'b0;
    i_valid   = 1'b0;
    i_op      = alu_op_pkg::OP_ADD;
    i_a       = '0;
    i_b       = '0;
    cycle_cnt = 0;
    issued    = 0;
    checked   = 0;
    seed      = 32'h0d4d_03b6;

    // outputs clear from the first reset edge on
    repeat (10) begin
      @(posedge RESET);
      #2;
      check_outputs_zero();
    end
    i_rst_n = 1'b1;
    repeat (2) begin
      drive_idle();
      check_outputs_zero();
    end

    // adds including the wrap to zero and the reserved op
    drive_op(alu_op_pkg::OP_ADD, 8'd3, 8'd4);
    drive_op(alu_op_pkg::OP_ADD, 8'd17, 8'd25);
    drive_op(alu_op_pkg::OP_ADD, '1, 8'd1);
    drive_op(alu_op_pkg::OP_RSVD, 8'd17, 8'd25);
    drive_op(alu_op_pkg::OP_RSVD, '1, 8'd1);
    // subtracts with greater, equal and borrow cases
    drive_op(alu_op_pkg::OP_SUB, 8'd50, 8'd8);
    drive_op(alu_op_pkg::OP_SUB, 8'd77, 8'd77);
    drive_op(alu_op_pkg::OP_SUB, 8'd5, 8'd9);
    // compares including the extremes
    drive_op(alu_op_pkg::OP_CMP, 8'd42, 8'd42);
    drive_op(alu_op_pkg::OP_CMP, 8'd43, 8'd42);
    drive_op(alu_op_pkg::OP_CMP, 8'd41, 8'd42);
    drive_op(alu_op_pkg::OP_CMP, '0, '1);
    drive_op(alu_op_pkg::OP_CMP, '1, '0);
    drive_op(alu_op_pkg::OP_CMP, '0, '0);
    drive_op(alu_op_pkg::OP_CMP, '1, '1);
    drive_idle();
    wait_for_drain();

    // random stream, valid on about three cycles in four
    while (issued < 15 + NUM_RANDOM) begin
      r = $random(seed);
      if (r[1:0] != 2'b00) begin
        ra = $random(seed);
        rb = $random(seed);
        drive_op(alu_op_pkg::alu_op_e'(r[3:2]), ra[W-1:0], rb[W-1:0]);
      end else begin
        drive_idle();
      end
    end
    drive_idle();
    wait_for_drain();

    // quiet cycles to catch a duplicated result
    repeat (5) drive_idle();
    if (checked == issued) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run("number of results differs from the number of operations issued");
    end
  end

endmodule
